// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_audio_recorder \
		-f audio_recorder_top.f -Mdir obj_dir
	out=$$(./obj_dir/Vtb_audio_recorder); echo "$$out"; \
		echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

// ==== audio_recorder_top.f ====
src/audio_pkg.sv
src/recorder_control.sv
src/i2s_capture.sv
src/i2s_playback.sv
src/speed_resampler.sv
src/sram_arbiter.sv
src/audio_recorder_top.sv
test/tb_codec_sram_models.sv
test/tb_audio_recorder.sv

// ==== src/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

	localparam int SAMPLE_WIDTH = 16;
	localparam int MAX_ADDR_WIDTH = 20;
	// one extra bit so a completely full memory still has a length
	localparam int LEN_WIDTH = MAX_ADDR_WIDTH + 1;

	typedef struct packed {
		logic valid;
		logic [SAMPLE_WIDTH-1:0] data;
	} sample_t;

	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		RECORD     = 3'd1,
		REC_PAUSE  = 3'd2,
		PLAY       = 3'd3,
		PLAY_PAUSE = 3'd4
	} mode_e;

	// slow flag on top, factor minus one below
	typedef struct packed {
		logic slow;
		logic [2:0] factor_m1;
	} speed_t;

	typedef struct packed {
		logic valid;
		logic [MAX_ADDR_WIDTH-1:0] addr;
		logic [SAMPLE_WIDTH-1:0] data;
	} mem_wr_t;

	typedef struct packed {
		logic valid;
		logic [MAX_ADDR_WIDTH-1:0] addr;
	} mem_rd_t;

	typedef struct packed {
		logic [LEN_WIDTH-1:0] length;
		speed_t speed;
	} play_cfg_t;

	// speed switches map straight onto speed_t
	function automatic speed_t decode_speed(input logic [3:0] level);
		speed_t s;
		s.slow = level[3];
		s.factor_m1 = level[2:0];
		return s;
	endfunction

endpackage

`default_nettype wire

// ==== src/audio_recorder_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_recorder_top
	import audio_pkg::*;
#(
	parameter int ADDR_WIDTH = 20
) (
	input wire i_clk,
	input wire i_reset,
	input wire i_key_record,
	input wire i_key_play,
	input wire i_key_stop,
	input wire [3:0] i_speed,
	input wire i_aud_bclk,
	input wire i_aud_adclrck,
	input wire i_aud_daclrck,
	input wire i_aud_adcdat,
	output logic o_aud_dacdat,
	output logic [ADDR_WIDTH-1:0] o_sram_addr,
	output logic [SAMPLE_WIDTH-1:0] o_sram_wdata,
	input wire [SAMPLE_WIDTH-1:0] i_sram_rdata,
	output logic o_sram_we_n,
	output logic o_sram_oe_n,
	output logic o_sram_ce_n,
	output mode_e o_mode
);

	sample_t capture;
	sample_t rd_data;
	mem_wr_t mem_wr;
	mem_rd_t mem_rd;
	play_cfg_t play_cfg;
	logic play_start;
	logic play_enable;
	logic play_done;
	logic sample_req;
	logic [SAMPLE_WIDTH-1:0] play_sample;

	recorder_control #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) recorder_control_inst (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_key_record(i_key_record),
		.i_key_play(i_key_play),
		.i_key_stop(i_key_stop),
		.i_speed(i_speed),
		.i_capture(capture),
		.i_play_done(play_done),
		.o_mem_wr(mem_wr),
		.o_play_cfg(play_cfg),
		.o_play_start(play_start),
		.o_play_enable(play_enable),
		.o_mode(o_mode)
	);

	// ADC side
	i2s_capture i2s_capture_inst (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_bclk(i_aud_bclk),
		.i_lrck(i_aud_adclrck),
		.i_dat(i_aud_adcdat),
		.o_sample(capture)
	);

	// DAC side
	i2s_playback i2s_playback_inst (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_bclk(i_aud_bclk),
		.i_lrck(i_aud_daclrck),
		.i_sample(play_sample),
		.o_sample_req(sample_req),
		.o_dat(o_aud_dacdat)
	);

	speed_resampler #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) speed_resampler_inst (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_play_start(play_start),
		.i_play_enable(play_enable),
		.i_play_cfg(play_cfg),
		.i_sample_req(sample_req),
		.i_rd_data(rd_data),
		.o_mem_rd(mem_rd),
		.o_sample(play_sample),
		.o_play_done(play_done)
	);

	sram_arbiter #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) sram_arbiter_inst (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_mem_wr(mem_wr),
		.i_mem_rd(mem_rd),
		.i_sram_rdata(i_sram_rdata),
		.o_rd_data(rd_data),
		.o_sram_addr(o_sram_addr),
		.o_sram_wdata(o_sram_wdata),
		.o_sram_we_n(o_sram_we_n),
		.o_sram_oe_n(o_sram_oe_n),
		.o_sram_ce_n(o_sram_ce_n)
	);

endmodule

`default_nettype wire

// ==== src/i2s_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_capture
	import audio_pkg::*;
(
	input wire i_clk,
	input wire i_reset,
	input wire i_bclk,
	input wire i_lrck,
	input wire i_dat,
	output sample_t o_sample
);

	// two sync stages plus one previous value
	logic [2:0] bclk_q;
	logic [2:0] lrck_q;
	logic [1:0] dat_q;
	logic bclk_rise;
	logic lrck_fall;
	logic take;
	logic active;
	logic [4:0] bit_cnt;
	logic [SAMPLE_WIDTH-1:0] shift;
	logic out_valid;
	logic [SAMPLE_WIDTH-1:0] out_data;

	assign bclk_rise = bclk_q[1] & ~bclk_q[2];
	assign lrck_fall = ~lrck_q[1] & lrck_q[2];
	assign take = active && bclk_rise && !lrck_fall;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			bclk_q <= '0;
			lrck_q <= '0;
			dat_q <= '0;
			active <= 1'b0;
			bit_cnt <= '0;
			out_valid <= 1'b0;
		end else begin
			bclk_q <= {bclk_q[1:0], i_bclk};
			lrck_q <= {lrck_q[1:0], i_lrck};
			dat_q <= {dat_q[0], i_dat};
			out_valid <= 1'b0;
			// left word starts, bit 0 is the I2S delay slot
			if (lrck_fall) begin
				active <= 1'b1;
				bit_cnt <= '0;
			end else if (take) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 5'(SAMPLE_WIDTH)) begin
					active <= 1'b0;
					out_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (take && bit_cnt != '0) begin
			shift <= {shift[SAMPLE_WIDTH-2:0], dat_q[1]};
		end
		if (take && bit_cnt == 5'(SAMPLE_WIDTH)) begin
			out_data <= {shift[SAMPLE_WIDTH-2:0], dat_q[1]};
		end
	end

	assign o_sample.valid = out_valid;
	assign o_sample.data = out_data;

endmodule

`default_nettype wire

// ==== src/i2s_playback.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_playback
	import audio_pkg::*;
(
	input wire i_clk,
	input wire i_reset,
	input wire i_bclk,
	input wire i_lrck,
	input wire [SAMPLE_WIDTH-1:0] i_sample,
	output logic o_sample_req,
	output logic o_dat
);

	logic [2:0] bclk_q;
	logic [2:0] lrck_q;
	logic bclk_fall;
	logic lrck_fall;
	logic active;
	logic [4:0] bit_cnt;
	logic [SAMPLE_WIDTH-1:0] shift;

	assign bclk_fall = ~bclk_q[1] & bclk_q[2];
	assign lrck_fall = ~lrck_q[1] & lrck_q[2];

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			bclk_q <= '0;
			lrck_q <= '0;
			o_sample_req <= 1'b0;
			o_dat <= 1'b0;
			active <= 1'b0;
			bit_cnt <= '0;
		end else begin
			bclk_q <= {bclk_q[1:0], i_bclk};
			lrck_q <= {lrck_q[1:0], i_lrck};
			o_sample_req <= lrck_fall;
			// the falling edge that moves LRCK carries no data
			if (lrck_fall) begin
				active <= 1'b1;
				bit_cnt <= '0;
			end else if (bclk_fall) begin
				if (active) begin
					o_dat <= shift[SAMPLE_WIDTH-1];
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 5'(SAMPLE_WIDTH - 1)) begin
						active <= 1'b0;
					end
				end else begin
					// rest of frame and right channel stay silent
					o_dat <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (lrck_fall) begin
			shift <= i_sample;
		end else if (bclk_fall && active) begin
			shift <= {shift[SAMPLE_WIDTH-2:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

// ==== src/recorder_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module recorder_control
	import audio_pkg::*;
#(
	parameter int ADDR_WIDTH = 20
) (
	input wire i_clk,
	input wire i_reset,
	input wire i_key_record,
	input wire i_key_play,
	input wire i_key_stop,
	input wire [3:0] i_speed,
	input wire sample_t i_capture,
	input wire i_play_done,
	output mem_wr_t o_mem_wr,
	output play_cfg_t o_play_cfg,
	output logic o_play_start,
	output logic o_play_enable,
	output mode_e o_mode
);

	mode_e mode;
	logic [ADDR_WIDTH-1:0] rec_addr;
	logic [LEN_WIDTH-1:0] rec_len;
	logic rec_wrap;
	logic start_pend;
	speed_t speed;
	logic wr_valid;
	logic [ADDR_WIDTH-1:0] wr_addr;
	logic [SAMPLE_WIDTH-1:0] wr_data;

	// last word of the memory
	assign rec_wrap = &rec_addr;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			mode <= IDLE;
			rec_addr <= '0;
			rec_len <= '0;
			start_pend <= 1'b0;
			o_play_start <= 1'b0;
			wr_valid <= 1'b0;
			speed <= '0;
		end else begin
			start_pend <= 1'b0;
			o_play_start <= start_pend;
			wr_valid <= 1'b0;
			// speed follows the switches, also while playing
			speed <= decode_speed(i_speed);
			case (mode)
				IDLE: begin
					if (i_key_record) begin
						rec_addr <= '0;
						mode <= RECORD;
					end else if (i_key_play && rec_len != '0) begin
						mode <= PLAY;
						start_pend <= 1'b1;
					end
				end
				RECORD, REC_PAUSE: begin
					if (i_key_stop) begin
						rec_len <= LEN_WIDTH'(rec_addr);
						mode <= IDLE;
					end else if (i_key_record) begin
						mode <= (mode == RECORD) ? REC_PAUSE : RECORD;
					end else if (mode == RECORD && i_capture.valid) begin
						wr_valid <= 1'b1;
						rec_addr <= rec_addr + 1'b1;
						// memory full, stop on our own
						if (rec_wrap) begin
							rec_len <= LEN_WIDTH'(1) << ADDR_WIDTH;
							mode <= IDLE;
						end
					end
				end
				PLAY, PLAY_PAUSE: begin
					if (i_key_stop || (mode == PLAY && i_play_done)) begin
						mode <= IDLE;
					end else if (i_key_play) begin
						mode <= (mode == PLAY) ? PLAY_PAUSE : PLAY;
					end
				end
				default: mode <= IDLE;
			endcase
		end
	end

	// write payload, valid comes from the block above
	always_ff @(posedge i_clk) begin
		if (i_capture.valid) begin
			wr_addr <= rec_addr;
			wr_data <= i_capture.data;
		end
	end

	assign o_mem_wr.valid = wr_valid;
	assign o_mem_wr.addr = MAX_ADDR_WIDTH'(wr_addr);
	assign o_mem_wr.data = wr_data;

	assign o_play_cfg.length = rec_len;
	assign o_play_cfg.speed = speed;
	assign o_play_enable = (mode == PLAY);
	assign o_mode = mode;

endmodule

`default_nettype wire

// ==== src/speed_resampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module speed_resampler
	import audio_pkg::*;
#(
	parameter int ADDR_WIDTH = 20
) (
	input wire i_clk,
	input wire i_reset,
	input wire i_play_start,
	input wire i_play_enable,
	input wire play_cfg_t i_play_cfg,
	input wire i_sample_req,
	input wire sample_t i_rd_data,
	output mem_rd_t o_mem_rd,
	output logic [SAMPLE_WIDTH-1:0] o_sample,
	output logic o_play_done
);

	logic [ADDR_WIDTH-1:0] play_addr;
	logic [2:0] rep_cnt;
	logic [SAMPLE_WIDTH-1:0] held;
	logic loaded;
	logic rd_valid;
	logic advance;
	logic step;
	logic [ADDR_WIDTH:0] next_addr;
	logic at_end;

	// only move on once the fetched word has actually arrived
	assign advance = i_sample_req && i_play_enable && loaded;

	// fast mode always steps, slow mode once the repeats are used up
	assign step = !i_play_cfg.speed.slow || rep_cnt >= i_play_cfg.speed.factor_m1;

	always_comb begin
		if (i_play_cfg.speed.slow) begin
			next_addr = {1'b0, play_addr} + 1'b1;
		end else begin
			next_addr = {1'b0, play_addr}
				+ (ADDR_WIDTH + 1)'(i_play_cfg.speed.factor_m1) + 1'b1;
		end
	end

	assign at_end = next_addr >= i_play_cfg.length[ADDR_WIDTH:0];

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			play_addr <= '0;
			rep_cnt <= '0;
			loaded <= 1'b0;
			rd_valid <= 1'b0;
			o_play_done <= 1'b0;
		end else begin
			rd_valid <= 1'b0;
			o_play_done <= 1'b0;
			if (i_play_start) begin
				play_addr <= '0;
				rep_cnt <= '0;
				loaded <= 1'b0;
				rd_valid <= 1'b1;
			end else begin
				if (i_rd_data.valid) begin
					loaded <= 1'b1;
				end
				if (advance) begin
					if (!step) begin
						rep_cnt <= rep_cnt + 1'b1;
					end else if (at_end) begin
						o_play_done <= 1'b1;
					end else begin
						play_addr <= next_addr[ADDR_WIDTH-1:0];
						rep_cnt <= '0;
						loaded <= 1'b0;
						rd_valid <= 1'b1;
					end
				end
			end
		end
	end

	// sample the DAC picks up at the next frame
	always_ff @(posedge i_clk) begin
		if (i_play_start) begin
			held <= '0;
		end else if (i_rd_data.valid) begin
			held <= i_rd_data.data;
		end
	end

	assign o_mem_rd.valid = rd_valid;
	assign o_mem_rd.addr = MAX_ADDR_WIDTH'(play_addr);
	assign o_sample = i_play_enable ? held : '0;

endmodule

`default_nettype wire

// ==== src/sram_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_arbiter
	import audio_pkg::*;
#(
	parameter int ADDR_WIDTH = 20
) (
	input wire i_clk,
	input wire i_reset,
	input wire mem_wr_t i_mem_wr,
	input wire mem_rd_t i_mem_rd,
	input wire [SAMPLE_WIDTH-1:0] i_sram_rdata,
	output sample_t o_rd_data,
	output logic [ADDR_WIDTH-1:0] o_sram_addr,
	output logic [SAMPLE_WIDTH-1:0] o_sram_wdata,
	output logic o_sram_we_n,
	output logic o_sram_oe_n,
	output logic o_sram_ce_n
);

	logic pend_valid;
	logic [ADDR_WIDTH-1:0] pend_addr;
	logic rd_req;
	logic [ADDR_WIDTH-1:0] rd_addr;
	logic rd_active;
	logic rd_valid;
	logic [SAMPLE_WIDTH-1:0] rd_word;

	// a waiting read goes before a new one
	assign rd_req = i_mem_rd.valid || pend_valid;
	assign rd_addr = pend_valid ? pend_addr : i_mem_rd.addr[ADDR_WIDTH-1:0];

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			pend_valid <= 1'b0;
			rd_active <= 1'b0;
			rd_valid <= 1'b0;
			o_sram_we_n <= 1'b1;
			o_sram_oe_n <= 1'b1;
			o_sram_ce_n <= 1'b1;
		end else begin
			rd_valid <= rd_active;
			rd_active <= 1'b0;
			if (i_mem_wr.valid) begin
				o_sram_we_n <= 1'b0;
				o_sram_oe_n <= 1'b1;
				o_sram_ce_n <= 1'b0;
				// write wins, park the read
				if (i_mem_rd.valid) begin
					pend_valid <= 1'b1;
				end
			end else if (rd_req) begin
				o_sram_we_n <= 1'b1;
				o_sram_oe_n <= 1'b0;
				o_sram_ce_n <= 1'b0;
				rd_active <= 1'b1;
				pend_valid <= 1'b0;
			end else begin
				o_sram_we_n <= 1'b1;
				o_sram_oe_n <= 1'b1;
				o_sram_ce_n <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_mem_wr.valid) begin
			o_sram_addr <= i_mem_wr.addr[ADDR_WIDTH-1:0];
			o_sram_wdata <= i_mem_wr.data;
		end else if (rd_req) begin
			o_sram_addr <= rd_addr;
		end
		if (i_mem_rd.valid) begin
			pend_addr <= i_mem_rd.addr[ADDR_WIDTH-1:0];
		end
		// async SRAM, data settles within the read cycle
		if (rd_active) begin
			rd_word <= i_sram_rdata;
		end
	end

	assign o_rd_data.valid = rd_valid;
	assign o_rd_data.data = rd_word;

endmodule

`default_nettype wire

// ==== test/tb_audio_recorder.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_audio_recorder
	import audio_pkg::*;
;

	localparam int ADDR_WIDTH = 6;
	// twice six tests of up to about 80 frames at 160 cycles each
	localparam int CYCLE_LIMIT = 150000;

	logic clk;
	logic reset;
	logic key_record;
	logic key_play;
	logic key_stop;
	logic [3:0] speed;
	logic [SAMPLE_WIDTH-1:0] adc_word;
	logic bclk;
	logic lrck;
	logic adcdat;
	logic dacdat;
	logic [7:0] phase;
	logic dac_valid;
	logic [SAMPLE_WIDTH-1:0] dac_word;
	logic [ADDR_WIDTH-1:0] sram_addr;
	logic [SAMPLE_WIDTH-1:0] sram_wdata;
	logic [SAMPLE_WIDTH-1:0] sram_rdata;
	logic sram_we_n;
	logic sram_oe_n;
	logic sram_ce_n;
	mode_e mode;

	int cycle_cnt;
	int error_count;
	int test_count;
	int failed_tests;
	logic [SAMPLE_WIDTH-1:0] dac_words[$];
	logic [SAMPLE_WIDTH-1:0] rec_words[$];
	logic [SAMPLE_WIDTH-1:0] expect_q[$];
	logic [SAMPLE_WIDTH-1:0] played[$];

	audio_recorder_top #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) audio_recorder_top_inst (
		.i_clk(clk),
		.i_reset(reset),
		.i_key_record(key_record),
		.i_key_play(key_play),
		.i_key_stop(key_stop),
		.i_speed(speed),
		.i_aud_bclk(bclk),
		.i_aud_adclrck(lrck),
		.i_aud_daclrck(lrck),
		.i_aud_adcdat(adcdat),
		.o_aud_dacdat(dacdat),
		.o_sram_addr(sram_addr),
		.o_sram_wdata(sram_wdata),
		.i_sram_rdata(sram_rdata),
		.o_sram_we_n(sram_we_n),
		.o_sram_oe_n(sram_oe_n),
		.o_sram_ce_n(sram_ce_n),
		.o_mode(mode)
	);

	tb_codec_model codec_inst (
		.i_clk(clk),
		.i_adc_word(adc_word),
		.i_dacdat(dacdat),
		.o_bclk(bclk),
		.o_lrck(lrck),
		.o_adcdat(adcdat),
		.o_phase(phase),
		.o_dac_valid(dac_valid),
		.o_dac_word(dac_word)
	);

	tb_sram_model #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) sram_inst (
		.i_clk(clk),
		.i_addr(sram_addr),
		.i_wdata(sram_wdata),
		.i_we_n(sram_we_n),
		.i_oe_n(sram_oe_n),
		.i_ce_n(sram_ce_n),
		.o_rdata(sram_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		if (dac_valid) begin
			dac_words.push_back(dac_word);
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic check_sample(input string name, input logic [SAMPLE_WIDTH-1:0] exp,
			input logic [SAMPLE_WIDTH-1:0] act);
		if (exp !== act) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_mode(input string name, input mode_e exp, input mode_e act);
		if (exp !== act) begin
			$display("[ERROR] %s: expected %s, actual %s", name, exp.name(), act.name());
			error_count++;
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
			error_count++;
		end
	endtask

	task automatic wait_phase(input int p);
		do @(posedge clk); while (int'(phase) != p);
	endtask

	// 0 record, 1 play, 2 stop
	task automatic press_key(input int which);
		key_record <= (which == 0);
		key_play <= (which == 1);
		key_stop <= (which == 2);
		@(posedge clk);
		key_record <= 1'b0;
		key_play <= 1'b0;
		key_stop <= 1'b0;
	endtask

	// words in [pause_from, pause_to) go out while recording is paused
	task automatic record_words(input int n, input int pause_from, input int pause_to,
			input bit do_stop);
		logic [SAMPLE_WIDTH-1:0] w;
		rec_words.delete();
		for (int i = 0; i < n; i++) begin
			wait_phase(100);
			do w = 16'($urandom); while (w == '0);
			adc_word <= w;
			if (!(i >= pause_from && i < pause_to) && rec_words.size() < 64) begin
				rec_words.push_back(w);
			end
			if (i == 0 || i == pause_from || i == pause_to) begin
				press_key(0);
			end
		end
		wait_phase(100);
		adc_word <= '0;
		if (do_stop) begin
			press_key(2);
		end
		@(posedge clk);
	endtask

	task automatic start_play(input logic [3:0] level);
		speed <= level;
		@(posedge clk);
		dac_words.delete();
		press_key(1);
	endtask

	// play may run a few frames beyond the expected words
	task automatic finish_play(input string name);
		int limit;
		int c;
		limit = (expect_q.size() + 8) * 160;
		c = 0;
		do begin
			@(posedge clk);
			c++;
		end while (mode != IDLE && c < limit);
		check_mode({name, " end of play"}, IDLE, mode);
		wait_phase(100);
		wait_phase(100);
		// SRAM idle once play is over
		check_level({name, " sram_ce_n"}, 1'b1, sram_ce_n);
		check_level({name, " sram_oe_n"}, 1'b1, sram_oe_n);
		check_level({name, " sram_we_n"}, 1'b1, sram_we_n);
		played.delete();
		foreach (dac_words[k]) begin
			if (dac_words[k] != '0) begin
				played.push_back(dac_words[k]);
			end
		end
	endtask

	task automatic compare_played(input string name);
		if (played.size() != expect_q.size()) begin
			$display("[ERROR] %s word count: expected %0d, actual %0d", name,
				expect_q.size(), played.size());
			error_count++;
		end
		for (int k = 0; k < played.size() && k < expect_q.size(); k++) begin
			check_sample(name, expect_q[k], played[k]);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic test_exact_playback();
		int e0;
		e0 = error_count;
		record_words(20, -1, -1, 1'b1);
		check_mode("exact_playback", IDLE, mode);
		for (int i = 0; i < 20; i++) begin
			check_sample("exact_playback sram", rec_words[i], sram_inst.mem[i]);
		end
		expect_q = rec_words;
		start_play(4'b0000);
		finish_play("exact_playback");
		compare_played("exact_playback");
		report_test("exact_playback", e0);
	endtask

	task automatic test_fast_speed();
		int e0;
		e0 = error_count;
		expect_q.delete();
		for (int i = 0; i < 20; i += 2) begin
			expect_q.push_back(rec_words[i]);
		end
		start_play(4'b0001);
		finish_play("fast_speed");
		compare_played("fast_speed");
		report_test("fast_speed", e0);
	endtask

	task automatic test_slow_speed();
		int e0;
		e0 = error_count;
		expect_q.delete();
		foreach (rec_words[i]) begin
			repeat (3) expect_q.push_back(rec_words[i]);
		end
		start_play(4'b1010);
		finish_play("slow_speed");
		compare_played("slow_speed");
		report_test("slow_speed", e0);
	endtask

	task automatic test_play_pause();
		int e0;
		int idx;
		e0 = error_count;
		expect_q = rec_words;
		start_play(4'b0000);
		repeat (6) wait_phase(100);
		press_key(1);
		idx = dac_words.size();
		repeat (3) wait_phase(100);
		check_mode("play_pause", PLAY_PAUSE, mode);
		for (int k = idx; k < dac_words.size(); k++) begin
			check_sample("play_pause silence", '0, dac_words[k]);
		end
		press_key(1);
		finish_play("play_pause");
		compare_played("play_pause");
		report_test("play_pause", e0);
	endtask

	task automatic test_record_pause();
		int e0;
		e0 = error_count;
		record_words(12, 4, 7, 1'b1);
		expect_q = rec_words;
		start_play(4'b0000);
		finish_play("record_pause");
		compare_played("record_pause");
		report_test("record_pause", e0);
	endtask

	task automatic test_full_memory();
		int e0;
		e0 = error_count;
		record_words(70, -1, -1, 1'b0);
		check_mode("full_memory", IDLE, mode);
		expect_q = rec_words;
		start_play(4'b0000);
		finish_play("full_memory");
		compare_played("full_memory");
		// silence once playback has ended
		check_sample("full_memory tail", '0, dac_words[dac_words.size()-1]);
		report_test("full_memory", e0);
	endtask

	initial begin
		void'($urandom(32'h01bced61));
		cycle_cnt = 0;
		error_count = 0;
		test_count = 0;
		failed_tests = 0;
		reset = 1'b1;
		key_record = 1'b0;
		key_play = 1'b0;
		key_stop = 1'b0;
		speed = 4'b0000;
		adc_word = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		check_mode("reset", IDLE, mode);
		check_level("reset sram_we_n", 1'b1, sram_we_n);
		check_level("reset sram_oe_n", 1'b1, sram_oe_n);
		check_level("reset sram_ce_n", 1'b1, sram_ce_n);
		check_level("reset dacdat", 1'b0, dacdat);
		test_exact_playback();
		test_fast_speed();
		test_slow_speed();
		test_play_pause();
		test_record_pause();
		test_full_memory();
		$display("tests run: %0d, failed: %0d, errors: %0d", test_count, failed_tests,
			error_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/tb_codec_sram_models.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_codec_model
	import audio_pkg::*;
(
	input wire i_clk,
	input wire [SAMPLE_WIDTH-1:0] i_adc_word,
	input wire i_dacdat,
	output logic o_bclk,
	output logic o_lrck,
	output logic o_adcdat,
	output logic [7:0] o_phase,
	output logic o_dac_valid,
	output logic [SAMPLE_WIDTH-1:0] o_dac_word
);

	logic [SAMPLE_WIDTH-1:0] adc_shift;
	logic [SAMPLE_WIDTH-1:0] dac_shift;

	initial begin
		o_bclk = 1'b1;
		o_lrck = 1'b1;
		o_adcdat = 1'b0;
		o_phase = 8'd159;
		o_dac_valid = 1'b0;
		o_dac_word = '0;
		adc_shift = '0;
		dac_shift = '0;
	end

	// 160 clock cycles per frame, 4 per BCLK, left half is LRCK low
	always @(negedge i_clk) begin
		int np;
		int b;
		np = (o_phase == 8'd159) ? 0 : int'(o_phase) + 1;
		b = np / 4;
		o_phase <= 8'(np);
		o_bclk <= (np % 4) >= 2;
		o_lrck <= (b >= 20);
		o_dac_valid <= (np == 72);
		if (np == 0) begin
			adc_shift <= i_adc_word;
		end
		if (np % 4 == 0) begin
			// MSB after one BCLK of delay
			o_adcdat <= (b >= 1 && b <= 16) ? adc_shift[16-b] : 1'b0;
			// DAC bit is settled by the following falling edge
			if (b >= 2 && b <= 17) begin
				dac_shift <= {dac_shift[SAMPLE_WIDTH-2:0], i_dacdat};
			end
		end
		if (np == 72) begin
			o_dac_word <= dac_shift;
		end
	end

endmodule

module tb_sram_model
	import audio_pkg::*;
#(
	parameter int ADDR_WIDTH = 6
) (
	input wire i_clk,
	input wire [ADDR_WIDTH-1:0] i_addr,
	input wire [SAMPLE_WIDTH-1:0] i_wdata,
	input wire i_we_n,
	input wire i_oe_n,
	input wire i_ce_n,
	output logic [SAMPLE_WIDTH-1:0] o_rdata
);

	logic [SAMPLE_WIDTH-1:0] mem [0:(1<<ADDR_WIDTH)-1];

	initial begin
		for (int a = 0; a < (1 << ADDR_WIDTH); a++) begin
			mem[a] = 16'(a) * 16'h0403 + 16'h1111;
		end
	end

	assign o_rdata = (!i_ce_n && !i_oe_n) ? mem[i_addr] : '0;

	always @(posedge i_clk) begin
		if (!i_ce_n && !i_we_n) begin
			mem[i_addr] <= i_wdata;
		end
	end

endmodule

`default_nettype wire
